// File: rtl/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

   // Payload word as produced by the pattern generator
   localparam int DATA_W = 8;

   // Entry = payload plus last-word marker on top
   localparam int ENTRY_W = DATA_W + 1;

   // Marker bit position inside an entry
   localparam int LAST_BIT = ENTRY_W - 1;

   // Default number of entries, power of two
   localparam int FIFO_DEPTH = 16;

   // Address width at the default depth
   localparam int PTR_W = $clog2(FIFO_DEPTH);

endpackage

// File: rtl/stream_pkg.sv
package stream_pkg;

   // Pattern selection for a burst
   typedef enum logic [1:0] {
      PAT_INCR  = 2'd0,  // seed, seed+1, ... wraps at 256
      PAT_LFSR  = 2'd1,  // x^8+x^6+x^5+x^4+1, shift left
      PAT_CONST = 2'd2   // Seed repeated
   } pattern_mode_e;

   // Producer FSM
   typedef enum logic {
      GEN_IDLE = 1'b0,
      GEN_RUN  = 1'b1
   } gen_state_e;

   // Consumer FSM
   typedef enum logic [1:0] {
      SINK_IDLE   = 2'd0,
      SINK_DRAIN  = 2'd1,
      SINK_REPORT = 2'd2
   } sink_state_e;

   // Checksum is a plain sum modulo 2^16
   localparam int SUM_W = 16;

   // Word count, wide enough for 256
   localparam int CNT_W = 9;

endpackage

// File: rtl/pattern_gen.sv
module pattern_gen (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                start,     // Already gated by the top
   input  stream_pkg::pattern_mode_e           mode,
   input  logic [fifo_cfg_pkg::DATA_W-1:0]     seed,
   input  logic [7:0]                          count,     // 0 means 256 words
   input  logic                                full,
   output logic                                wr_en,
   output logic [fifo_cfg_pkg::ENTRY_W-1:0]    wr_data
);

   stream_pkg::gen_state_e                state;
   stream_pkg::pattern_mode_e             mode_q;     // Mode of the running burst
   logic [fifo_cfg_pkg::DATA_W-1:0]       cur_word;   // Word offered to the FIFO
   logic [fifo_cfg_pkg::DATA_W-1:0]       next_word;
   logic [fifo_cfg_pkg::DATA_W-1:0]       first_word;
   logic [stream_pkg::CNT_W-1:0]          remaining;  // Words still to write, incl. current
   logic [stream_pkg::CNT_W-1:0]          rem_load;
   logic                                  last_word;
   logic                                  lfsr_fb;

   // Burst length, zero count stands for a full 256
   always_comb begin
      if (count == '0) begin
         rem_load = stream_pkg::CNT_W'(256);
      end else begin
         rem_load = stream_pkg::CNT_W'(count);
      end
   end

   // LFSR cannot start from zero, so swap in 1
   always_comb begin
      first_word = seed;
      if ((mode == stream_pkg::PAT_LFSR) && (seed == '0)) begin
         first_word = fifo_cfg_pkg::DATA_W'(1);
      end
   end

   // Feedback for taps 8,6,5,4
   assign lfsr_fb = cur_word[7] ^ cur_word[5] ^ cur_word[4] ^ cur_word[3];

   // Next pattern value, only taken on an accepted write
   always_comb begin
      case (mode_q)
         stream_pkg::PAT_INCR:  next_word = cur_word + 1'b1;  // Natural wrap
         stream_pkg::PAT_LFSR:  next_word = {cur_word[6:0], lfsr_fb};
         stream_pkg::PAT_CONST: next_word = cur_word;
         default:               next_word = cur_word;         // Unused code acts as const
      endcase
   end

   assign last_word = (remaining == stream_pkg::CNT_W'(1));

   // Write whenever running and the FIFO has room
   assign wr_en   = (state == stream_pkg::GEN_RUN) && !full;
   assign wr_data = {last_word, cur_word};  // Marker in the top bit

   // Control FSM and burst counter
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= stream_pkg::GEN_IDLE;
         remaining <= '0;
      end else begin
         case (state)
            stream_pkg::GEN_IDLE: begin
               if (start) begin
                  state     <= stream_pkg::GEN_RUN;
                  remaining <= rem_load;
               end
            end
            stream_pkg::GEN_RUN: begin
               if (wr_en) begin
                  remaining <= remaining - 1'b1;
                  // Marker word just went out
                  if (last_word) begin
                     state <= stream_pkg::GEN_IDLE;
                  end
               end
            end
            default: state <= stream_pkg::GEN_IDLE;
         endcase
      end
   end

   // Pattern registers, loaded on start and stepped per write
   always_ff @(posedge clk) begin
      if ((state == stream_pkg::GEN_IDLE) && start) begin
         mode_q   <= mode;
         cur_word <= first_word;
      end else if (wr_en) begin
         cur_word <= next_word;   // Held while full
      end
   end

endmodule

// File: rtl/fifo.sv
module fifo #(
   parameter int DEPTH = fifo_cfg_pkg::FIFO_DEPTH  // Power of two, at least 2
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              wr_en,    // Never raised while full
   input  logic [fifo_cfg_pkg::ENTRY_W-1:0]  wr_data,
   output logic                              full,
   input  logic                              rd_en,    // Never raised while empty
   output logic [fifo_cfg_pkg::ENTRY_W-1:0]  rd_data,
   output logic                              empty
);

   // Pointer width follows the actual depth
   localparam int AW = $clog2(DEPTH);

   logic [fifo_cfg_pkg::ENTRY_W-1:0]  mem [DEPTH];
   logic [AW-1:0]                     wr_ptr;
   logic [AW-1:0]                     rd_ptr;
   logic [AW:0]                       occupancy;   // 0 .. DEPTH

   // Flags straight off the registered count
   assign full  = (occupancy == (AW + 1)'(DEPTH));
   assign empty = (occupancy == '0);

   // Storage write
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Registered read port, data shows up after the read edge
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_ptr];
      end
   end

   // Pointers wrap naturally at a power-of-two depth
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Occupancy count
   always_ff @(posedge clk) begin
      if (reset) begin
         occupancy <= '0;
      end else begin
         case ({wr_en, rd_en})
            2'b10:   occupancy <= occupancy + 1'b1;
            2'b01:   occupancy <= occupancy - 1'b1;
            default: occupancy <= occupancy;   // Idle or read+write together
         endcase
      end
   end

endmodule

// File: rtl/checksum_sink.sv
module checksum_sink (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              start,       // Same start the generator sees
   input  logic                              drain_en,
   input  logic                              empty,
   output logic                              rd_en,
   input  logic [fifo_cfg_pkg::ENTRY_W-1:0]  rd_data,
   output logic                              busy,
   output logic                              done,
   output logic [stream_pkg::SUM_W-1:0]      checksum,
   output logic [stream_pkg::CNT_W-1:0]      word_count
);

   stream_pkg::sink_state_e            state;
   logic                               rd_valid;   // rd_data holds a fresh word
   logic [fifo_cfg_pkg::DATA_W-1:0]    payload;
   logic                               marker;

   assign payload = rd_data[fifo_cfg_pkg::DATA_W-1:0];
   assign marker  = rd_data[fifo_cfg_pkg::LAST_BIT];

   // Pull a word whenever allowed, the marker word is always the last one queued
   assign rd_en = (state == stream_pkg::SINK_DRAIN) && drain_en && !empty;

   // Busy drops in the cycle that carries done
   assign busy = (state == stream_pkg::SINK_DRAIN);
   assign done = (state == stream_pkg::SINK_REPORT);  // One cycle only

   // Read data lags rd_en by one edge
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_en;
      end
   end

   // FSM plus accumulators
   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= stream_pkg::SINK_IDLE;
         checksum   <= '0;
         word_count <= '0;
      end else begin
         case (state)
            stream_pkg::SINK_IDLE: begin
               if (start) begin
                  state      <= stream_pkg::SINK_DRAIN;
                  checksum   <= '0;
                  word_count <= '0;
               end
            end
            stream_pkg::SINK_DRAIN: begin
               if (rd_valid) begin
                  checksum   <= checksum + stream_pkg::SUM_W'(payload);  // Mod 2^16
                  word_count <= word_count + 1'b1;
                  if (marker) begin
                     state <= stream_pkg::SINK_REPORT;
                  end
               end
            end
            stream_pkg::SINK_REPORT: begin
               // Results held; a start here opens the next burst at once
               if (start) begin
                  state      <= stream_pkg::SINK_DRAIN;
                  checksum   <= '0;
                  word_count <= '0;
               end else begin
                  state <= stream_pkg::SINK_IDLE;
               end
            end
            default: state <= stream_pkg::SINK_IDLE;
         endcase
      end
   end

endmodule

// File: rtl/stream_top.sv
module stream_top (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              start,      // One-cycle command pulse
   input  stream_pkg::pattern_mode_e         mode,
   input  logic [fifo_cfg_pkg::DATA_W-1:0]   seed,
   input  logic [7:0]                        count,      // 0 means 256
   input  logic                              drain_en,   // Sink may read
   output logic                              busy,
   output logic                              done,
   output logic [stream_pkg::SUM_W-1:0]      checksum,
   output logic [stream_pkg::CNT_W-1:0]      word_count
);

   logic                              start_ok;   // Accepted start, common to both ends
   logic                              wr_en;
   logic [fifo_cfg_pkg::ENTRY_W-1:0]  wr_data;
   logic                              full;
   logic                              rd_en;
   logic [fifo_cfg_pkg::ENTRY_W-1:0]  rd_data;
   logic                              empty;

   // Starts during a burst are dropped
   assign start_ok = start && !busy;

   // Producer
   pattern_gen u_gen (
      .clk     (clk),
      .reset   (reset),
      .start   (start_ok),
      .mode    (mode),
      .seed    (seed),
      .count   (count),
      .full    (full),
      .wr_en   (wr_en),
      .wr_data (wr_data)
   );

   // Buffer between the two ends
   fifo #(
      .DEPTH (fifo_cfg_pkg::FIFO_DEPTH)
   ) u_fifo (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .full    (full),
      .rd_en   (rd_en),
      .rd_data (rd_data),
      .empty   (empty)
   );

   // Consumer, also owns busy and done
   checksum_sink u_sink (
      .clk        (clk),
      .reset      (reset),
      .start      (start_ok),
      .drain_en   (drain_en),
      .empty      (empty),
      .rd_en      (rd_en),
      .rd_data    (rd_data),
      .busy       (busy),
      .done       (done),
      .checksum   (checksum),
      .word_count (word_count)
   );

endmodule

// File: verif/fifo_chk.sv
module fifo_chk #(
   parameter int DEPTH = fifo_cfg_pkg::FIFO_DEPTH
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    wr_en,
   input  logic                    rd_en,
   input  logic                    full,
   input  logic                    empty,
   input  logic [$clog2(DEPTH):0]  occupancy   // Same width as inside the FIFO
);

   timeunit 1ns;
   timeprecision 1ps;

   // Failures seen so far, read by the testbench at the end of the run
   int fail_count = 0;

   // Producer must honour full
   a_no_write_full: assert property (@(posedge clk) disable iff (reset) full |-> !wr_en)
      else begin
         $error("FIFO written while full");
         fail_count++;
      end

   // Consumer must honour empty
   a_no_read_empty: assert property (@(posedge clk) disable iff (reset) empty |-> !rd_en)
      else begin
         $error("FIFO read while empty");
         fail_count++;
      end

   a_flags_exclusive: assert property (@(posedge clk) disable iff (reset) !(full && empty))
      else begin
         $error("full and empty high together");
         fail_count++;
      end

   // Count stays within the storage
   a_occ_bound: assert property (@(posedge clk) disable iff (reset) occupancy <= DEPTH)
      else begin
         $error("FIFO occupancy above its depth");
         fail_count++;
      end

endmodule

// One checker per FIFO instance, depth taken from the instance
bind fifo fifo_chk #(.DEPTH(DEPTH)) u_fifo_chk (
   .clk       (clk),
   .reset     (reset),
   .wr_en     (wr_en),
   .rd_en     (rd_en),
   .full      (full),
   .empty     (empty),
   .occupancy (occupancy)
);

// File: verif/tb_stream_top.sv
module tb_stream_top;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int     CLK_PERIOD     = 40;
   localparam int     RESET_CYCLES   = 16;
   localparam int     STALL_FACTOR   = 8;      // Worst slowdown from back-pressure
   localparam int     BURST_OVERHEAD = 64;     // Start, pipeline and report cycles
   localparam int     TOTAL_WORDS    = 881;    // Sum of all burst lengths below
   localparam int     N_BURSTS       = 11;
   localparam int     QUIET_CYCLES   = 300;    // Window after the ignored start
   localparam longint WATCHDOG_NS    = longint'(TOTAL_WORDS * STALL_FACTOR
                                         + N_BURSTS * BURST_OVERHEAD
                                         + RESET_CYCLES + QUIET_CYCLES + 100) * CLK_PERIOD;
   localparam int     RES_W          = stream_pkg::CNT_W + stream_pkg::SUM_W;

   logic                                clk = 1'b0;
   logic                                reset;
   logic                                start;
   stream_pkg::pattern_mode_e           mode;
   logic [fifo_cfg_pkg::DATA_W-1:0]     seed;
   logic [7:0]                          count;
   logic                                drain_en;
   logic                                busy;
   logic                                done;
   logic [stream_pkg::SUM_W-1:0]        checksum;
   logic [stream_pkg::CNT_W-1:0]        word_count;

   logic [RES_W-1:0]  exp_q [$];     // {word_count, checksum} per accepted command
   logic [RES_W-1:0]  exp_res;
   logic [RES_W-1:0]  first_res;
   int                errors     = 0;
   int                checks     = 0;
   int                tests      = 0;
   int                done_count = 0;
   int                err_mark;
   int                done_mark;
   bit                drain_random = 1'b0;   // drain_en follows $urandom when set
   bit                full_seen    = 1'b0;
   logic [7:0]        rnd_seed;
   int                i;

   always #(CLK_PERIOD / 2) clk = ~clk;

   stream_top u_stream_top (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .mode       (mode),
      .seed       (seed),
      .count      (count),
      .drain_en   (drain_en),
      .busy       (busy),
      .done       (done),
      .checksum   (checksum),
      .word_count (word_count)
   );

   // Expected {count, sum} of one burst from the pattern rules
   function automatic logic [RES_W-1:0] ref_burst(input stream_pkg::pattern_mode_e m,
                                                  input logic [7:0] s,
                                                  input logic [7:0] c);
      logic [stream_pkg::SUM_W-1:0]  sum;
      logic [stream_pkg::CNT_W-1:0]  n;
      logic [7:0]                    w;
      n = (c == 8'd0) ? 9'd256 : {1'b0, c};   // Zero stands for 256
      w = s;
      if ((m == stream_pkg::PAT_LFSR) && (s == 8'd0)) begin
         w = 8'h01;                           // LFSR never starts at zero
      end
      sum = '0;
      for (int k = 0; k < int'(n); k++) begin
         sum = sum + w;                       // Wraps at 2^16
         case (m)
            stream_pkg::PAT_INCR: w = w + 8'd1;
            stream_pkg::PAT_LFSR: w = {w[6:0], w[7] ^ w[5] ^ w[4] ^ w[3]};
            default:              w = w;
         endcase
      end
      return {n, sum};
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   // Pulse start with a command that is accepted on the second edge
   task automatic issue(input stream_pkg::pattern_mode_e m, input logic [7:0] s,
                        input logic [7:0] c);
      @(posedge clk);
      start <= 1'b1;
      mode  <= m;
      seed  <= s;
      count <= c;
      @(posedge clk);
      start <= 1'b0;
   endtask

   // Wait for done with a cycle limit and let the comparator finish
   task automatic wait_done(input int max_cycles);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!done && (n < max_cycles));
      if (!done) begin
         $display("no done pulse within %0d cycles at %0t ns", max_cycles, $time);
         errors++;
      end
      @(posedge clk);
   endtask

   task automatic run_burst(input stream_pkg::pattern_mode_e m, input logic [7:0] s,
                            input logic [7:0] c);
      int n;
      n = (c == 8'd0) ? 256 : int'(c);
      exp_q.push_back(ref_burst(m, s, c));
      issue(m, s, c);
      wait_done(n * STALL_FACTOR + BURST_OVERHEAD);
   endtask

   task automatic report_test(input string name, input int err_before);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "FAILED");
   endtask

   // Comparator samples mid-cycle where done and results are stable
   always @(negedge clk) begin
      if (!reset && done) begin
         done_count++;
         if (exp_q.size() == 0) begin
            $display("done pulse at %0t ns with no command pending", $time);
            errors++;
         end else begin
            exp_res = exp_q.pop_front();
            check_value(word_count, exp_res[RES_W-1:stream_pkg::SUM_W], "word_count");
            check_value(checksum, exp_res[stream_pkg::SUM_W-1:0], "checksum");
         end
      end
   end

   always @(posedge clk) begin
      if (drain_random) begin
         drain_en <= ($urandom() % 2) != 0;   // New level every cycle
      end
   end

   always @(negedge clk) begin
      if (u_stream_top.full) begin
         full_seen = 1'b1;                    // Back-pressure reached the generator
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("Checks failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h4f2e_8007));
      reset    = 1'b1;
      start    = 1'b0;
      mode     = stream_pkg::PAT_INCR;
      seed     = '0;
      count    = '0;
      drain_en = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      // Reset values of all outputs
      err_mark = errors;
      @(negedge clk);
      check_value(busy, 0, "busy after reset");
      check_value(done, 0, "done after reset");
      check_value(checksum, 0, "checksum after reset");
      check_value(word_count, 0, "word_count after reset");
      report_test("reset state", err_mark);

      // Incrementing pattern with a last burst that wraps past 255
      err_mark = errors;
      run_burst(stream_pkg::PAT_INCR, 8'h00, 8'd1);
      run_burst(stream_pkg::PAT_INCR, 8'h10, 8'd16);
      run_burst(stream_pkg::PAT_INCR, 8'h37, 8'd100);
      run_burst(stream_pkg::PAT_INCR, 8'hF0, 8'd40);
      report_test("incrementing pattern", err_mark);

      // LFSR from seed 0 and then from random seeds
      err_mark = errors;
      run_burst(stream_pkg::PAT_LFSR, 8'h00, 8'd64);
      for (i = 0; i < 3; i++) begin
         rnd_seed = 8'($urandom());
         run_burst(stream_pkg::PAT_LFSR, rnd_seed, 8'd64);
      end
      report_test("LFSR pattern", err_mark);

      // Constant pattern under random drain so the FIFO fills
      err_mark = errors;
      full_seen    = 1'b0;
      drain_random = 1'b1;
      rnd_seed     = 8'($urandom());
      run_burst(stream_pkg::PAT_CONST, rnd_seed, 8'd200);
      drain_random = 1'b0;
      drain_en <= 1'b1;
      check_value(full_seen, 1, "FIFO full during back-pressure");
      report_test("constant pattern with back-pressure", err_mark);

      // A count of 0 is a full 256-word burst
      err_mark = errors;
      run_burst(stream_pkg::PAT_INCR, 8'h80, 8'd0);
      check_value(word_count, 256, "word_count of 256-word burst");
      report_test("256-word burst", err_mark);

      // Second start while the sink still drains is dropped
      err_mark  = errors;
      first_res = ref_burst(stream_pkg::PAT_INCR, 8'h21, 8'd12);
      exp_q.push_back(first_res);
      drain_en <= 1'b0;                            // Hold the sink so the generator finishes
      issue(stream_pkg::PAT_INCR, 8'h21, 8'd12);
      repeat (20) @(posedge clk);
      @(negedge clk);
      check_value(busy, 1, "busy before second start");
      issue(stream_pkg::PAT_CONST, 8'hAA, 8'd5);   // Generator idle, must not be accepted
      drain_en <= 1'b1;
      wait_done(12 * STALL_FACTOR + BURST_OVERHEAD);
      done_mark = done_count;
      repeat (QUIET_CYCLES) @(negedge clk);
      check_value(done_count - done_mark, 0, "extra done pulses");
      check_value(u_stream_top.empty, 1, "FIFO empty after ignored start");
      check_value(checksum, first_res[stream_pkg::SUM_W-1:0], "held checksum");
      check_value(word_count, first_res[RES_W-1:stream_pkg::SUM_W], "held word_count");
      report_test("start while busy", err_mark);

      // Assertion failures from the bound FIFO checker count as errors
      errors += u_stream_top.u_fifo.u_fifo_chk.fail_count;
      if (exp_q.size() != 0) begin
         $display("%0d commands never produced a done pulse", exp_q.size());
         errors++;
      end

      $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: Bender.yml
package:
  name: stream_fifo

sources:
  # Packages first, then the data path from leaf to top
  - files:
      - rtl/fifo_cfg_pkg.sv
      - rtl/stream_pkg.sv
      - rtl/pattern_gen.sv
      - rtl/fifo.sv
      - rtl/checksum_sink.sv
      - rtl/stream_top.sv

  # Bound FIFO checker and the testbench
  - target: test
    files:
      - verif/fifo_chk.sv
      - verif/tb_stream_top.sv

// File: tb.f
rtl/fifo_cfg_pkg.sv
rtl/stream_pkg.sv
rtl/pattern_gen.sv
rtl/fifo.sv
rtl/checksum_sink.sv
rtl/stream_top.sv
verif/fifo_chk.sv
verif/tb_stream_top.sv
